// ==== hdl/aes_sparse_pkg.sv ====
// Sparse 2-value encoding for 3 rails; any value other than SP2V_HIGH or SP2V_LOW is a fault
package aes_sparse_pkg;

  //////////////////////////////////////////////////
  // Sparse two-value encoding
  //////////////////////////////////////////////////

  // Bits per sparse value, one rail per bit
  parameter int Sp2VWidth = 3;

  // Hamming distance 3 between the two legal values
  typedef enum logic [Sp2VWidth-1:0] {
    SP2V_HIGH = 3'b011,
    SP2V_LOW  = 3'b100
  } sp2v_e;

  //////////////////////////////////////////////////
  // Per-rail polarity
  //////////////////////////////////////////////////

  // Bit set: that rail sees a true signal as 1
  // Bit clear: that rail sees a true signal as 0
  // Matches SP2V_HIGH so that a plain all-true rail vector maps onto it
  parameter logic [Sp2VWidth-1:0] SP2V_LOGIC_HIGH = 3'b011;

endpackage

// ==== hdl/aes_ctr_pkg.sv ====
// Counter is fixed at 128 bits (16 bytes); byte reversal assumes whole bytes throughout
package aes_ctr_pkg;

  //////////////////////////////////////////////////
  // Counter geometry
  //////////////////////////////////////////////////

  parameter int CtrWidth    = 128;
  parameter int CtrNumBytes = CtrWidth / 8;

  // Rail FSM states, pairwise distance 2
  // Any other value is treated as a fault
  typedef enum logic [2:0] {
    CTR_IDLE  = 3'b011,
    CTR_INCR  = 3'b101,
    CTR_ERROR = 3'b110
  } ctr_state_e;

  // Swap byte order of the whole counter
  // Big-endian register order to numeric order and back
  function automatic logic [CtrWidth-1:0] aes_rev_bytes(logic [CtrWidth-1:0] in);
    logic [CtrWidth-1:0] out;
    for (int i = 0; i < CtrNumBytes; i++) begin
      out[8*i +: 8] = in[8*(CtrNumBytes-1-i) +: 8];
    end
    return out;
  endfunction

endpackage

// ==== hdl/aes_ctr_rail_in.sv ====
// Combinational feeder; SliceSize must be a multiple of 8 dividing 128, slice index is not range-checked
`timescale 1ns/1ps

module aes_ctr_rail_in #(
  parameter  int SliceSize     = 16,
  localparam int NumSlices     = aes_ctr_pkg::CtrWidth / SliceSize,
  localparam int SliceIdxWidth = (NumSlices > 1) ? $clog2(NumSlices) : 1
) (
  input  aes_sparse_pkg::sp2v_e                incr_i,
  input  logic [aes_ctr_pkg::CtrWidth-1:0]     ctr_i,
  input  logic [SliceIdxWidth-1:0]             ctr_slice_idx_i,
  output logic [aes_sparse_pkg::Sp2VWidth-1:0] rail_incr_o,
  output logic                                 incr_err_o,
  output logic [SliceSize-1:0]                 ctr_slice_o
);

  import aes_sparse_pkg::*;
  import aes_ctr_pkg::*;

  // Counter in numeric byte order
  logic [CtrWidth-1:0] ctr_rev;

  //////////////////////////////////////////////////
  // Strobe check and rail fan-out
  //////////////////////////////////////////////////

  // Only the two legal codes pass
  assign incr_err_o = !((incr_i == SP2V_HIGH) || (incr_i == SP2V_LOW));

  // Undo per-rail polarity
  // SP2V_HIGH gives all ones, SP2V_LOW all zeros
  // A faulty code leaves the rails split, but incr_err_o catches it
  assign rail_incr_o = ~(incr_i ^ SP2V_LOGIC_HIGH);

  //////////////////////////////////////////////////
  // Slice selection
  //////////////////////////////////////////////////

  assign ctr_rev = aes_rev_bytes(ctr_i);

  // Slice 0 is the least significant in numeric order
  // Index comes back from the merged rail outputs
  assign ctr_slice_o = ctr_rev[ctr_slice_idx_i * SliceSize +: SliceSize];

endmodule

// ==== hdl/aes_ctr_rail_fsm.sv ====
// One increment rail; all inputs are plain active high, polarity is handled outside the rail
`timescale 1ns/1ps

module aes_ctr_rail_fsm #(
  parameter  int SliceSize     = 16,
  localparam int NumSlices     = aes_ctr_pkg::CtrWidth / SliceSize,
  localparam int SliceIdxWidth = (NumSlices > 1) ? $clog2(NumSlices) : 1
) (
  input  logic                     clk_i,
  input  logic                     rst_i,
  input  logic                     incr_i,
  input  logic                     incr_err_i,
  input  logic                     mr_err_i,
  input  logic [SliceSize-1:0]     ctr_slice_i,
  output logic                     ready_o,
  output logic                     alert_o,
  output logic [SliceIdxWidth-1:0] ctr_slice_idx_o,
  output logic [SliceSize-1:0]     ctr_slice_o,
  output logic                     ctr_we_o
);

  import aes_ctr_pkg::*;

  // Index of the final slice
  localparam logic [SliceIdxWidth-1:0] LastIdx = SliceIdxWidth'(NumSlices - 1);

  ctr_state_e               state_q, state_d;
  logic [SliceIdxWidth-1:0] slice_idx_q, slice_idx_d;
  logic                     carry_q, carry_d;

  // Slice sum with overflow in the top bit
  logic [SliceSize:0]       slice_sum;

  assign slice_sum = {1'b0, ctr_slice_i} + {{SliceSize{1'b0}}, carry_q};

  //////////////////////////////////////////////////
  // Next state and outputs
  //////////////////////////////////////////////////

  always_comb begin
    state_d     = state_q;
    slice_idx_d = slice_idx_q;
    carry_d     = carry_q;
    ready_o     = 1'b0;
    alert_o     = 1'b0;
    ctr_we_o    = 1'b0;
    // Unchanged slice unless incrementing
    ctr_slice_o = ctr_slice_i;

    unique case (state_q)
      CTR_IDLE: begin
        ready_o = 1'b1;
        if (incr_i) begin
          // Start at the low end, add one
          state_d     = CTR_INCR;
          slice_idx_d = '0;
          carry_d     = 1'b1;
        end
      end

      CTR_INCR: begin
        // One slice per cycle
        ctr_slice_o = slice_sum[SliceSize-1:0];
        ctr_we_o    = 1'b1;
        carry_d     = slice_sum[SliceSize];
        slice_idx_d = slice_idx_q + 1'b1;
        if (slice_idx_q == LastIdx) begin
          state_d     = CTR_IDLE;
          slice_idx_d = '0;
        end
      end

      CTR_ERROR: begin
        // Terminal, only reset leaves
        alert_o = 1'b1;
      end

      default: begin
        // Corrupted state register
        state_d = CTR_ERROR;
      end
    endcase

    // Bad strobe or rail disagreement wins over everything
    if (incr_err_i || mr_err_i) begin
      state_d = CTR_ERROR;
    end
  end

  //////////////////////////////////////////////////
  // Registers
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q     <= CTR_IDLE;
      slice_idx_q <= '0;
      carry_q     <= 1'b0;
    end else begin
      state_q     <= state_d;
      slice_idx_q <= slice_idx_d;
      carry_q     <= carry_d;
    end
  end

  assign ctr_slice_idx_o = slice_idx_q;

endmodule

// ==== hdl/aes_ctr_rail_merge.sv ====
// Combinational merge; ctr_we_o[j] enables ctr_o[j*SliceSize +: SliceSize], j=0 is most significant
`timescale 1ns/1ps

module aes_ctr_rail_merge #(
  parameter  int SliceSize     = 16,
  localparam int NumSlices     = aes_ctr_pkg::CtrWidth / SliceSize,
  localparam int SliceIdxWidth = (NumSlices > 1) ? $clog2(NumSlices) : 1
) (
  input  logic [aes_sparse_pkg::Sp2VWidth-1:0]                    rail_ready_i,
  input  logic [aes_sparse_pkg::Sp2VWidth-1:0]                    rail_alert_i,
  input  logic [aes_sparse_pkg::Sp2VWidth-1:0][SliceIdxWidth-1:0] rail_slice_idx_i,
  input  logic [aes_sparse_pkg::Sp2VWidth-1:0][SliceSize-1:0]     rail_slice_i,
  input  logic [aes_sparse_pkg::Sp2VWidth-1:0]                    rail_we_i,
  input  logic [aes_ctr_pkg::CtrWidth-1:0]                        ctr_i,
  output aes_sparse_pkg::sp2v_e                                   ready_o,
  output logic                                                    alert_o,
  output logic [aes_ctr_pkg::CtrWidth-1:0]                        ctr_o,
  output aes_sparse_pkg::sp2v_e [NumSlices-1:0]                   ctr_we_o,
  output logic [SliceIdxWidth-1:0]                                ctr_slice_idx_o,
  output logic                                                    mr_err_o
);

  import aes_sparse_pkg::*;
  import aes_ctr_pkg::*;

  logic [SliceSize-1:0]    slice_or;
  sp2v_e                   ctr_we;
  logic [CtrWidth-1:0]     ctr_i_rev;
  logic [CtrWidth-1:0]     ctr_o_rev;
  sp2v_e [NumSlices-1:0]   ctr_we_rev;

  //////////////////////////////////////////////////
  // Single-bit rail outputs
  //////////////////////////////////////////////////

  // Put per-rail polarity back
  assign ready_o = sp2v_e'(~(rail_ready_i ^ SP2V_LOGIC_HIGH));
  assign ctr_we  = sp2v_e'(~(rail_we_i ^ SP2V_LOGIC_HIGH));

  // One rail is enough to raise the alert
  assign alert_o = |rail_alert_i;

  //////////////////////////////////////////////////
  // Multi-bit rail outputs
  //////////////////////////////////////////////////

  // OR all rails, then flag any rail that differs
  always_comb begin
    ctr_slice_idx_o = '0;
    slice_or        = '0;
    mr_err_o        = 1'b0;
    for (int i = 0; i < Sp2VWidth; i++) begin
      ctr_slice_idx_o |= rail_slice_idx_i[i];
      slice_or        |= rail_slice_i[i];
    end
    for (int i = 0; i < Sp2VWidth; i++) begin
      if ((rail_slice_idx_i[i] != ctr_slice_idx_o) || (rail_slice_i[i] != slice_or)) begin
        mr_err_o = 1'b1;
      end
    end
  end

  //////////////////////////////////////////////////
  // Write-back in register order
  //////////////////////////////////////////////////

  assign ctr_i_rev = aes_rev_bytes(ctr_i);

  // Drop the new slice into the numeric-order counter
  always_comb begin
    ctr_o_rev = ctr_i_rev;
    ctr_o_rev[ctr_slice_idx_o * SliceSize +: SliceSize] = slice_or;
  end

  // Only the active slice may be enabled
  always_comb begin
    ctr_we_rev                  = {NumSlices{SP2V_LOW}};
    ctr_we_rev[ctr_slice_idx_o] = ctr_we;
  end

  assign ctr_o = aes_rev_bytes(ctr_o_rev);

  // Slice order flips together with the bytes
  always_comb begin
    for (int i = 0; i < NumSlices; i++) begin
      ctr_we_o[i] = ctr_we_rev[NumSlices-1-i];
    end
  end

endmodule

// ==== hdl/aes_ctr.sv ====
// CTR increment top level; SliceSize must be a multiple of 8 that divides 128, owner applies writes
`timescale 1ns/1ps

module aes_ctr #(
  parameter  int SliceSize     = 16,
  localparam int NumSlices     = aes_ctr_pkg::CtrWidth / SliceSize,
  localparam int SliceIdxWidth = (NumSlices > 1) ? $clog2(NumSlices) : 1
) (
  input  logic                                  clk_i,
  input  logic                                  rst_i,
  input  aes_sparse_pkg::sp2v_e                 incr_i,
  output aes_sparse_pkg::sp2v_e                 ready_o,
  output logic                                  alert_o,
  input  logic [aes_ctr_pkg::CtrWidth-1:0]      ctr_i,
  output logic [aes_ctr_pkg::CtrWidth-1:0]      ctr_o,
  output aes_sparse_pkg::sp2v_e [NumSlices-1:0] ctr_we_o
);

  import aes_sparse_pkg::*;

  // Feeder to rails
  logic [Sp2VWidth-1:0]                    rail_incr;
  logic                                    incr_err;
  logic [SliceSize-1:0]                    ctr_slice;

  // Rails to merge
  logic [Sp2VWidth-1:0]                    rail_ready;
  logic [Sp2VWidth-1:0]                    rail_alert;
  logic [Sp2VWidth-1:0][SliceIdxWidth-1:0] rail_slice_idx;
  logic [Sp2VWidth-1:0][SliceSize-1:0]     rail_slice;
  logic [Sp2VWidth-1:0]                    rail_we;

  // Merge feedback
  logic [SliceIdxWidth-1:0]                ctr_slice_idx;
  logic                                    mr_err;

  //////////////////////////////////////////////////
  // Input side
  //////////////////////////////////////////////////

  aes_ctr_rail_in #(
    .SliceSize (SliceSize)
  ) u_rail_in (
    .incr_i          (incr_i),
    .ctr_i           (ctr_i),
    .ctr_slice_idx_i (ctr_slice_idx),
    .rail_incr_o     (rail_incr),
    .incr_err_o      (incr_err),
    .ctr_slice_o     (ctr_slice)
  );

  //////////////////////////////////////////////////
  // Redundant rails, one per sparse bit
  //////////////////////////////////////////////////

  for (genvar i = 0; i < Sp2VWidth; i++) begin : gen_rail
    aes_ctr_rail_fsm #(
      .SliceSize (SliceSize)
    ) u_rail_fsm (
      .clk_i           (clk_i),
      .rst_i           (rst_i),
      .incr_i          (rail_incr[i]),
      .incr_err_i      (incr_err),
      .mr_err_i        (mr_err),
      .ctr_slice_i     (ctr_slice),
      .ready_o         (rail_ready[i]),
      .alert_o         (rail_alert[i]),
      .ctr_slice_idx_o (rail_slice_idx[i]),
      .ctr_slice_o     (rail_slice[i]),
      .ctr_we_o        (rail_we[i])
    );
  end

  //////////////////////////////////////////////////
  // Output side
  //////////////////////////////////////////////////

  aes_ctr_rail_merge #(
    .SliceSize (SliceSize)
  ) u_rail_merge (
    .rail_ready_i     (rail_ready),
    .rail_alert_i     (rail_alert),
    .rail_slice_idx_i (rail_slice_idx),
    .rail_slice_i     (rail_slice),
    .rail_we_i        (rail_we),
    .ctr_i            (ctr_i),
    .ready_o          (ready_o),
    .alert_o          (alert_o),
    .ctr_o            (ctr_o),
    .ctr_we_o         (ctr_we_o),
    .ctr_slice_idx_o  (ctr_slice_idx),
    .mr_err_o         (mr_err)
  );

endmodule

// ==== bench/aes_ctr_properties.sv ====
// Port-level checks bound into aes_ctr; relies on the sp2v_e codes of aes_sparse_pkg
`timescale 1ns/1ps

module aes_ctr_properties #(
  parameter  int SliceSize = 16,
  localparam int NumSlices = aes_ctr_pkg::CtrWidth / SliceSize
) (
  input logic                                  clk_i,
  input logic                                  rst_i,
  input aes_sparse_pkg::sp2v_e                 ready_o,
  input logic                                  alert_o,
  input aes_sparse_pkg::sp2v_e [NumSlices-1:0] ctr_we_o
);

  import aes_sparse_pkg::*;

  // One bit per slice, set while its enable is HIGH
  logic [NumSlices-1:0] we_high;

  always_comb begin
    for (int j = 0; j < NumSlices; j++) begin
      we_high[j] = (ctr_we_o[j] == SP2V_HIGH);
    end
  end

  ////////////////////////////////////////////////////
  // Assertions
  ////////////////////////////////////////////////////

  we_one_slice: assert property (@(posedge clk_i) disable iff (rst_i) $onehot0(we_high))
    else $error("ctr_we_o enables more than one slice");

  // Sticky until reset
  alert_sticky: assert property (@(posedge clk_i) disable iff (rst_i) alert_o |=> alert_o)
    else $error("alert_o dropped without reset");

  ready_valid: assert property (@(posedge clk_i) disable iff (rst_i)
    (ready_o == SP2V_HIGH) || (ready_o == SP2V_LOW))
    else $error("ready_o holds an invalid encoding");

endmodule

// ==== bench/aes_ctr_tb.sv ====
// Counter owner model and table checks for SliceSize 16; the invalid-strobe row must stay last
`timescale 1ns/1ps

module aes_ctr_tb;

  import aes_sparse_pkg::*;
  import aes_ctr_pkg::*;

  localparam int SliceSize     = 16;
  localparam int NumSlices     = CtrWidth / SliceSize;
  localparam int RstCycles     = 10;
  localparam int NumRows       = 10;
  localparam int TimeoutCycles = NumRows * (NumSlices + 6) + RstCycles;

  // One stimulus row
  typedef struct packed {
    logic                rand_start;
    logic [CtrWidth-1:0] start;
    logic [2:0]          incr;
    logic                exp_alert;
    logic                restrobe;
  } row_t;

  logic                  clk_i;
  logic                  rst_i;
  sp2v_e                 incr_i;
  sp2v_e                 ready_o;
  logic                  alert_o;
  logic [CtrWidth-1:0]   ctr_q = '0;
  logic [CtrWidth-1:0]   ctr_o;
  sp2v_e [NumSlices-1:0] ctr_we_o;

  logic                  load_req;
  logic [CtrWidth-1:0]   load_val;
  row_t                  rows [NumRows];
  logic [31:0]           lcg_state;
  int                    cycles = 0;
  int                    checks;
  int                    errors;

  aes_ctr #(
    .SliceSize (SliceSize)
  ) UUT (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .incr_i   (incr_i),
    .ready_o  (ready_o),
    .alert_o  (alert_o),
    .ctr_i    (ctr_q),
    .ctr_o    (ctr_o),
    .ctr_we_o (ctr_we_o)
  );

  bind aes_ctr aes_ctr_properties #(
    .SliceSize (SliceSize)
  ) u_props (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .ready_o  (ready_o),
    .alert_o  (alert_o),
    .ctr_we_o (ctr_we_o)
  );

  always #4 clk_i = ~clk_i;

  ////////////////////////////////////////////////////
  // Counter register owned outside the DUT
  ////////////////////////////////////////////////////

  // Slice j of the enable vector covers ctr_o[j*SliceSize +: SliceSize]
  always @(posedge clk_i) begin
    if (rst_i || load_req) begin
      ctr_q <= load_val;
    end else begin
      for (int j = 0; j < NumSlices; j++) begin
        if (ctr_we_o[j] == SP2V_HIGH) begin
          ctr_q[j*SliceSize +: SliceSize] <= ctr_o[j*SliceSize +: SliceSize];
        end
      end
    end
  end

  // Run limit
  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles >= TimeoutCycles) begin
      $display("Timeout: run did not finish within %0d cycles", TimeoutCycles);
      $display("TESTS FAILED");
      $finish;
    end
  end

  ////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // Register byte order to numeric order, and back
  function automatic logic [CtrWidth-1:0] swap_bytes(input logic [CtrWidth-1:0] v);
    logic [CtrWidth-1:0] r;
    for (int b = 0; b < CtrWidth / 8; b++) begin
      r[8*b +: 8] = v[CtrWidth-8-8*b +: 8];
    end
    return r;
  endfunction

  function automatic int we_high_count();
    int n;
    n = 0;
    for (int j = 0; j < NumSlices; j++) begin
      if (ctr_we_o[j] == SP2V_HIGH) begin
        n++;
      end
    end
    return n;
  endfunction

  task automatic draw_random(output logic [CtrWidth-1:0] v);
    for (int w = 0; w < CtrWidth / 32; w++) begin
      lcg_state = lcg_next(lcg_state);
      v[32*w +: 32] = lcg_state;
    end
  endtask

  task automatic compare_value(input string name, input logic [CtrWidth-1:0] act,
                               input logic [CtrWidth-1:0] exp);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("ERROR time=%0t %s actual=%h expected=%h", $time, name, act, exp);
    end
  endtask

  task automatic wait_ready();
    while (ready_o != SP2V_HIGH) begin
      @(posedge clk_i);
      #1;
    end
  endtask

  ////////////////////////////////////////////////////
  // Stimulus table
  ////////////////////////////////////////////////////

  task automatic fill_table();
    // Plain increment, low byte below 255
    rows[0] = '{1'b0, 128'h000102030405060708090a0b0c0d0e0f, SP2V_HIGH, 1'b0, 1'b0};
    // Carry across a byte inside the low slice
    rows[1] = '{1'b0, 128'hff00eeddccbbaa998877665544332211, SP2V_HIGH, 1'b0, 1'b0};
    // Carry across several slices
    rows[2] = '{1'b0, 128'hffffffffffff0000efcdab8967452301, SP2V_HIGH, 1'b0, 1'b0};
    // Full wrap
    rows[3] = '{1'b0, {CtrWidth{1'b1}}, SP2V_HIGH, 1'b0, 1'b0};
    // LCG start values
    rows[4] = '{1'b1, '0, SP2V_HIGH, 1'b0, 1'b0};
    rows[5] = '{1'b1, '0, SP2V_HIGH, 1'b0, 1'b0};
    rows[6] = '{1'b1, '0, SP2V_HIGH, 1'b0, 1'b0};
    rows[7] = '{1'b1, '0, SP2V_HIGH, 1'b0, 1'b0};
    // Second strobe while busy
    rows[8] = '{1'b0, 128'hfedcba98765432100123456789abffff, SP2V_HIGH, 1'b0, 1'b1};
    // Invalid encoding, terminal
    rows[9] = '{1'b0, 128'h0f0e0d0c0b0a09080706050403020100, 3'b111, 1'b1, 1'b0};
  endtask

  task automatic run_row(input int r);
    logic [CtrWidth-1:0] start;
    logic [CtrWidth-1:0] expected;
    int                  waited;
    if (rows[r].rand_start) begin
      draw_random(start);
    end else begin
      start = rows[r].start;
    end
    expected = swap_bytes(swap_bytes(start) + 128'd1);
    wait_ready();
    load_val = start;
    load_req = 1'b1;
    @(posedge clk_i);
    #1;
    load_req = 1'b0;
    incr_i   = sp2v_e'(rows[r].incr);
    waited   = 0;
    // Sample first, then drive the next strobe value
    do begin
      @(posedge clk_i);
      #1;
      incr_i = (rows[r].restrobe && waited == 2) ? SP2V_HIGH : SP2V_LOW;
      waited++;
    end while ((ready_o != SP2V_HIGH) && !alert_o);
    compare_value("alert_o", 128'(alert_o), 128'(rows[r].exp_alert));
    if (!rows[r].exp_alert) begin
      compare_value("ready_o latency", 128'(waited), 128'(NumSlices + 1));
      compare_value("ctr_q", ctr_q, expected);
    end else begin
      // Alert must hold with no further writes
      repeat (4) begin
        @(posedge clk_i);
        #1;
        compare_value("alert_o", 128'(alert_o), 128'd1);
        compare_value("ready_o", 128'(ready_o), 128'(SP2V_LOW));
        compare_value("ctr_we_o high count", 128'(we_high_count()), 128'd0);
      end
      compare_value("ctr_q", ctr_q, start);
    end
  endtask

  ////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////

  initial begin
    clk_i     = 1'b0;
    rst_i     = 1'b1;
    incr_i    = SP2V_LOW;
    load_req  = 1'b0;
    load_val  = '0;
    lcg_state = 32'h413bdc5f;
    checks    = 0;
    errors    = 0;
    fill_table();
    repeat (RstCycles) @(posedge clk_i);
    #1;
    rst_i = 1'b0;
    // Idle outputs straight after reset
    compare_value("ready_o", 128'(ready_o), 128'(SP2V_HIGH));
    compare_value("alert_o", 128'(alert_o), 128'd0);
    compare_value("ctr_we_o high count", 128'(we_high_count()), 128'd0);
    for (int r = 0; r < NumRows; r++) begin
      run_row(r);
    end
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

// ==== vlog.f ====
hdl/aes_sparse_pkg.sv
hdl/aes_ctr_pkg.sv
hdl/aes_ctr_rail_in.sv
hdl/aes_ctr_rail_fsm.sv
hdl/aes_ctr_rail_merge.sv
hdl/aes_ctr.sv
bench/aes_ctr_properties.sv
bench/aes_ctr_tb.sv

// ==== Makefile ====
TOP = aes_ctr_tb

all: run

build:
	verilator --binary --timing --assert -f vlog.f --top-module $(TOP) -Mdir obj_dir

run: build
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -qx "TESTS PASSED"

lint:
	verilator --lint-only --timing -Wall -f vlog.f --top-module $(TOP)

clean:
	rm -rf obj_dir

.PHONY: all build run lint clean
